//--- Bender.yml
package:
  name: cfg_backbone

sources:
  - include_dirs:
      - src
    files:
      - src/cfg_pkg.sv
      - src/bus_pkg.sv
      - src/reset_chain.sv
      - src/init_sequencer.sv
      - src/host_regs.sv
      - src/dev_bus_arbiter.sv
      - src/cfg_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/cfg_top_chk.sv
      - verification/tb_cfg_top.sv

//--- src/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// device side wishbone
	typedef logic [7:0] dev_adr_t;
	typedef logic [31:0] dev_dat_t;

	// host side wishbone
	typedef logic [3:0] host_adr_t;
	typedef logic [31:0] host_dat_t;

	// host register map, byte offsets
	localparam host_adr_t REG_STATUS = 4'h0;   // {chain_done, done_seen}
	localparam host_adr_t REG_RESTART = 4'h4;  // write strobes a chain restart
	localparam host_adr_t REG_CMD_ADR = 4'h8;  // live command address
	localparam host_adr_t REG_CMD_DAT = 4'hC;  // access runs a device transfer

endpackage

`default_nettype wire

//--- src/cfg_init_table.svh
// device init writes, issued in order after the init step leaves reset
// entry layout: address in the top byte, data below it

localparam int INIT_LEN = 6;

localparam cfg_pkg::init_cmd_t INIT_TABLE [INIT_LEN] = '{
	{8'h10, 32'h0000_0001},  // soft reset release
	{8'h11, 32'h0000_00A5},
	{8'h12, 32'h1234_5678},  // clock divider setup
	{8'h13, 32'hDEAD_0001},
	{8'h14, 32'h0F0F_0F0F},  // lane mask
	{8'h15, 32'h8000_0000}   // enable, last
};

//--- src/cfg_pkg.sv
`default_nettype none

package cfg_pkg;

	// chain shape
	localparam int NSTEP_DEFAULT = 4;
	localparam int INIT_STEP_DEFAULT = 2;   // step driven by the init sequencer
	localparam int RESET_LEN_DEFAULT = 20;  // hold cycles per step

	typedef logic [3:0] step_vec_t;   // one bit per chained step
	typedef logic [15:0] step_cnt_t;  // hold counter

	// init table entry, device address in [39:32], write data in [31:0]
	typedef logic [39:0] init_cmd_t;

	// reset chain FSM
	typedef enum logic [1:0] {
		CH_IDLE,
		CH_HOLD,  // active step held in reset
		CH_WAIT,  // waiting on the step's done criterion
		CH_DONE
	} chain_state_t;

	// init sequencer FSM
	typedef enum logic [1:0] {
		SQ_IDLE,
		SQ_ISSUE,
		SQ_WAIT_ACK,
		SQ_DONE
	} seq_state_t;

endpackage

`default_nettype wire

//--- src/cfg_top.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_top #(
	parameter int NSTEP = cfg_pkg::NSTEP_DEFAULT,
	parameter int INIT_STEP = cfg_pkg::INIT_STEP_DEFAULT,
	parameter int RESET_LEN = cfg_pkg::RESET_LEN_DEFAULT
) (
	input wire logic clkcfg,
	input wire logic poweronreset,
	input wire logic [NSTEP-2:0] ext_done,
	output cfg_pkg::step_vec_t step_reset,
	input wire logic host_cyc,
	input wire logic host_stb,
	input wire logic host_we,
	input wire bus_pkg::host_adr_t host_adr,
	input wire bus_pkg::host_dat_t host_dat_w,
	output bus_pkg::host_dat_t host_dat_r,
	output logic host_ack,
	output logic dev_cyc,
	output logic dev_stb,
	output logic dev_we,
	output bus_pkg::dev_adr_t dev_adr,
	output bus_pkg::dev_dat_t dev_dat_w,
	input wire bus_pkg::dev_dat_t dev_dat_r,
	input wire logic dev_ack
);
	import cfg_pkg::*;
	import bus_pkg::*;

	step_vec_t done;
	step_vec_t done_seen;
	logic chain_done;
	logic restart;
	logic init_done;
	logic init_cyc;
	logic init_stb;
	logic init_we;
	logic init_ack;
	dev_adr_t init_adr;
	dev_dat_t init_dat_w;
	logic req_cyc;
	logic req_stb;
	logic req_we;
	logic req_ack;
	dev_adr_t req_adr;
	dev_dat_t req_dat_w;
	dev_dat_t req_dat_r;

	// init step reports its own done, the rest come in on ext_done in order
	for (genvar i = 0; i < $bits(step_vec_t); i++) begin : g_done
		if (i >= NSTEP) begin : g_unused
			assign done[i] = 1'b0;
		end else if (i == INIT_STEP) begin : g_init
			assign done[i] = init_done;
		end else if (i < INIT_STEP) begin : g_below
			assign done[i] = ext_done[i];
		end else begin : g_above
			assign done[i] = ext_done[i-1];
		end
	end

	reset_chain #(
		.NSTEP(NSTEP),
		.RESET_LEN(RESET_LEN)
	) u_reset_chain (
		.clkcfg(clkcfg),
		.poweronreset(poweronreset),
		.restart(restart),
		.done(done),
		.step_reset(step_reset),
		.done_seen(done_seen),
		.chain_done(chain_done)
	);

	init_sequencer u_init_sequencer (
		.clkcfg(clkcfg),
		.step_rst(step_reset[INIT_STEP]),
		.cyc(init_cyc),
		.stb(init_stb),
		.we(init_we),
		.adr(init_adr),
		.dat_w(init_dat_w),
		.ack(init_ack),
		.init_done(init_done)
	);

	host_regs u_host_regs (
		.clkcfg(clkcfg),
		.poweronreset(poweronreset),
		.host_cyc(host_cyc),
		.host_stb(host_stb),
		.host_we(host_we),
		.host_adr(host_adr),
		.host_dat_w(host_dat_w),
		.host_dat_r(host_dat_r),
		.host_ack(host_ack),
		.done_seen(done_seen),
		.chain_done(chain_done),
		.restart(restart),
		.req_cyc(req_cyc),
		.req_stb(req_stb),
		.req_we(req_we),
		.req_adr(req_adr),
		.req_dat_w(req_dat_w),
		.req_ack(req_ack),
		.req_dat_r(req_dat_r)
	);

	dev_bus_arbiter u_dev_bus_arbiter (
		.clkcfg(clkcfg),
		.poweronreset(poweronreset),
		.init_done(init_done),
		.init_cyc(init_cyc),
		.init_stb(init_stb),
		.init_we(init_we),
		.init_adr(init_adr),
		.init_dat_w(init_dat_w),
		.init_ack(init_ack),
		.host_cyc(req_cyc),
		.host_stb(req_stb),
		.host_we(req_we),
		.host_adr(req_adr),
		.host_dat_w(req_dat_w),
		.host_ack(req_ack),
		.host_dat_r(req_dat_r),
		.dev_cyc(dev_cyc),
		.dev_stb(dev_stb),
		.dev_we(dev_we),
		.dev_adr(dev_adr),
		.dev_dat_w(dev_dat_w),
		.dev_dat_r(dev_dat_r),
		.dev_ack(dev_ack)
	);

endmodule

`default_nettype wire

//--- src/dev_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module dev_bus_arbiter (
	input wire logic clkcfg,
	input wire logic poweronreset,
	input wire logic init_done,
	input wire logic init_cyc,
	input wire logic init_stb,
	input wire logic init_we,
	input wire bus_pkg::dev_adr_t init_adr,
	input wire bus_pkg::dev_dat_t init_dat_w,
	output logic init_ack,
	input wire logic host_cyc,
	input wire logic host_stb,
	input wire logic host_we,
	input wire bus_pkg::dev_adr_t host_adr,
	input wire bus_pkg::dev_dat_t host_dat_w,
	output logic host_ack,
	output bus_pkg::dev_dat_t host_dat_r,
	output logic dev_cyc,
	output logic dev_stb,
	output logic dev_we,
	output bus_pkg::dev_adr_t dev_adr,
	output bus_pkg::dev_dat_t dev_dat_w,
	input wire bus_pkg::dev_dat_t dev_dat_r,
	input wire logic dev_ack
);
	import bus_pkg::*;

	logic gnt_host;     // 0 = init sequencer owns the bus
	dev_dat_t rd_data;

	// grant only moves while the bus is idle
	always_ff @(posedge clkcfg) begin
		if (poweronreset)
			gnt_host <= 1'b0;
		else if (!dev_cyc)
			gnt_host <= init_done;
	end

	assign dev_cyc = gnt_host ? host_cyc : init_cyc;
	assign dev_stb = gnt_host ? host_stb : init_stb;
	assign dev_we = gnt_host ? host_we : init_we;
	assign dev_adr = gnt_host ? host_adr : init_adr;
	assign dev_dat_w = gnt_host ? host_dat_w : init_dat_w;

	assign init_ack = dev_ack && !gnt_host;
	assign host_ack = dev_ack && gnt_host;

	always_ff @(posedge clkcfg) begin
		if (dev_ack && dev_cyc && !dev_we)
			rd_data <= dev_dat_r;
	end

	assign host_dat_r = rd_data;  // valid from the cycle after the read ack

endmodule

`default_nettype wire

//--- src/host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module host_regs (
	input wire logic clkcfg,
	input wire logic poweronreset,
	input wire logic host_cyc,
	input wire logic host_stb,
	input wire logic host_we,
	input wire bus_pkg::host_adr_t host_adr,
	input wire bus_pkg::host_dat_t host_dat_w,
	output bus_pkg::host_dat_t host_dat_r,
	output logic host_ack,
	input wire cfg_pkg::step_vec_t done_seen,
	input wire logic chain_done,
	output logic restart,
	output logic req_cyc,
	output logic req_stb,
	output logic req_we,
	output bus_pkg::dev_adr_t req_adr,
	output bus_pkg::dev_dat_t req_dat_w,
	input wire logic req_ack,
	input wire bus_pkg::dev_dat_t req_dat_r
);
	import bus_pkg::*;

	dev_adr_t cmd_adr;     // target of live device commands
	host_dat_t reg_rdata;  // local register read value
	logic dev_rd;          // current ack returns device read data
	logic access;
	logic cmd_dat;

	// new access: strobe up and not already answered
	assign access = host_cyc && host_stb && !host_ack;
	assign cmd_dat = (host_adr == REG_CMD_DAT);

	// device data is captured by the arbiter on its ack, valid during our ack
	assign host_dat_r = dev_rd ? req_dat_r : reg_rdata;

	always_ff @(posedge clkcfg) begin
		if (poweronreset) begin
			host_ack <= 1'b0;
			restart <= 1'b0;
			req_cyc <= 1'b0;
			req_stb <= 1'b0;
			req_we <= 1'b0;
			cmd_adr <= '0;
			reg_rdata <= '0;
			dev_rd <= 1'b0;
		end else begin
			host_ack <= 1'b0;
			restart <= 1'b0;
			if (req_cyc) begin
				// host ack held back until the device answers
				if (req_ack) begin
					req_cyc <= 1'b0;
					req_stb <= 1'b0;
					host_ack <= 1'b1;
					dev_rd <= !req_we;
				end
			end else if (access) begin
				dev_rd <= 1'b0;
				if (cmd_dat) begin
					req_cyc <= 1'b1;
					req_stb <= 1'b1;
					req_we <= host_we;
				end else begin
					host_ack <= 1'b1;  // local registers answer next cycle
					case (host_adr)
						REG_STATUS: reg_rdata <= host_dat_t'({chain_done, done_seen});
						REG_RESTART: begin
							reg_rdata <= '0;
							restart <= host_we;  // single cycle strobe
						end
						REG_CMD_ADR: begin
							if (host_we)
								cmd_adr <= dev_adr_t'(host_dat_w);
							reg_rdata <= host_dat_t'(cmd_adr);
						end
						default: reg_rdata <= '0;
					endcase
				end
			end
		end
	end

	// command payload, latched when the device transfer starts
	always_ff @(posedge clkcfg) begin
		if (access && cmd_dat && !req_cyc) begin
			req_adr <= cmd_adr;
			req_dat_w <= dev_dat_t'(host_dat_w);
		end
	end

endmodule

`default_nettype wire

//--- src/init_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module init_sequencer (
	input wire logic clkcfg,
	input wire logic step_rst,
	output logic cyc,
	output logic stb,
	output logic we,
	output bus_pkg::dev_adr_t adr,
	output bus_pkg::dev_dat_t dat_w,
	input wire logic ack,
	output logic init_done
);
	import cfg_pkg::*;

	`include "cfg_init_table.svh"

	localparam int IW = (INIT_LEN > 1) ? $clog2(INIT_LEN) : 1;

	seq_state_t state;
	logic [IW-1:0] idx;  // table entry in flight

	assign we = cyc;  // table holds writes only

	always_ff @(posedge clkcfg) begin
		if (step_rst) begin
			state <= SQ_IDLE;
			idx <= '0;
			cyc <= 1'b0;
			stb <= 1'b0;
			init_done <= 1'b0;
		end else begin
			case (state)
				SQ_IDLE: state <= SQ_ISSUE;
				SQ_ISSUE: begin
					cyc <= 1'b1;
					stb <= 1'b1;
					state <= SQ_WAIT_ACK;
				end
				SQ_WAIT_ACK: begin
					if (ack) begin
						cyc <= 1'b0;  // bus drops the cycle after ack
						stb <= 1'b0;
						if (idx == IW'(INIT_LEN - 1)) begin
							init_done <= 1'b1;
							state <= SQ_DONE;
						end else begin
							idx <= idx + 1'b1;
							state <= SQ_ISSUE;
						end
					end
				end
				SQ_DONE: state <= SQ_DONE;  // until the step reset returns
			endcase
		end
	end

	// address and data load with the strobe and stay put until ack
	always_ff @(posedge clkcfg) begin
		if (state == SQ_ISSUE)
			{adr, dat_w} <= INIT_TABLE[idx];
	end

endmodule

`default_nettype wire

//--- src/reset_chain.sv
`timescale 1ns/1ps
`default_nettype none

module reset_chain #(
	parameter int NSTEP = cfg_pkg::NSTEP_DEFAULT,
	parameter int RESET_LEN = cfg_pkg::RESET_LEN_DEFAULT
) (
	input wire logic clkcfg,
	input wire logic poweronreset,
	input wire logic restart,
	input wire cfg_pkg::step_vec_t done,
	output cfg_pkg::step_vec_t step_reset,
	output cfg_pkg::step_vec_t done_seen,
	output logic chain_done
);
	import cfg_pkg::*;

	localparam int IW = (NSTEP > 1) ? $clog2(NSTEP) : 1;

	chain_state_t state;
	logic [IW-1:0] idx;  // active step
	step_cnt_t hold_cnt;

	// one step at a time: hold its reset, release it, then wait for its done
	// steps above idx keep their reset asserted until their turn
	always_ff @(posedge clkcfg) begin
		if (poweronreset || restart) begin
			state <= CH_IDLE;
			idx <= '0;
			hold_cnt <= '0;
			step_reset <= '1;  // everything back in reset
			done_seen <= '0;
			chain_done <= 1'b0;
		end else begin
			case (state)
				CH_IDLE: begin
					hold_cnt <= '0;
					state <= CH_HOLD;
				end
				CH_HOLD: begin
					hold_cnt <= hold_cnt + 1'b1;
					if (hold_cnt == step_cnt_t'(RESET_LEN - 1)) begin
						step_reset[idx] <= 1'b0;  // RESET_LEN cycles in hold
						state <= CH_WAIT;
					end
				end
				CH_WAIT: begin
					if (done[idx]) begin
						done_seen[idx] <= 1'b1;
						if (idx == IW'(NSTEP - 1)) begin
							chain_done <= 1'b1;
							state <= CH_DONE;
						end else begin
							// next step starts its hold in the following cycle
							idx <= idx + 1'b1;
							hold_cnt <= '0;
							state <= CH_HOLD;
						end
					end
				end
				CH_DONE: begin
					state <= CH_DONE;  // parked until a restart
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/cfg_pkg.sv
src/bus_pkg.sv
src/reset_chain.sv
src/init_sequencer.sv
src/host_regs.sv
src/dev_bus_arbiter.sv
src/cfg_top.sv
verification/cfg_top_chk.sv
verification/tb_cfg_top.sv

//--- verification/cfg_top_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_top_chk #(
	parameter int NSTEP = cfg_pkg::NSTEP_DEFAULT,
	parameter int RESET_LEN = cfg_pkg::RESET_LEN_DEFAULT
) (
	input wire logic clkcfg,
	input wire logic poweronreset,
	input wire logic restart,
	input wire cfg_pkg::step_vec_t step_reset,
	input wire cfg_pkg::step_vec_t done,
	input wire logic init_done,
	input wire logic req_ack,
	input wire logic dev_cyc,
	input wire logic dev_stb,
	input wire logic dev_we,
	input wire bus_pkg::dev_adr_t dev_adr,
	input wire bus_pkg::dev_dat_t dev_dat_w,
	input wire logic dev_ack,
	input wire logic host_cyc,
	input wire logic host_stb,
	input wire logic host_we,
	input wire bus_pkg::host_adr_t host_adr,
	input wire bus_pkg::host_dat_t host_dat_w,
	input wire logic host_ack
);
	int unsigned fail_cnt = 0;  // failed assertions so far

	// device request frozen from strobe until ack
	a_dev_hold: assert property (@(posedge clkcfg) disable iff (poweronreset)
		dev_cyc && dev_stb && !dev_ack |=> dev_cyc && dev_stb && $stable(dev_we)
			&& $stable(dev_adr) && $stable(dev_dat_w))
		else begin
			fail_cnt++;
			$error("device request changed or dropped before ack");
		end

	a_host_hold: assert property (@(posedge clkcfg) disable iff (poweronreset)
		host_cyc && host_stb && !host_ack |=> $stable(host_we)
			&& $stable(host_adr) && $stable(host_dat_w))
		else begin
			fail_cnt++;
			$error("host request changed before ack");
		end

	// the idle cycle plus RESET_LEN hold cycles
	a_step0_hold: assert property (@(posedge clkcfg)
		(poweronreset || restart) ##1 !(poweronreset || restart)
			|-> step_reset[0] [*(RESET_LEN + 1)] ##1 !step_reset[0])
		else begin
			fail_cnt++;
			$error("step 0 reset hold length wrong");
		end

	// host commands reach the device only once init is through
	a_host_after_init: assert property (@(posedge clkcfg) disable iff (poweronreset)
		req_ack |-> init_done)
		else begin
			fail_cnt++;
			$error("host device transfer before init done");
		end

	for (genvar i = 0; i < NSTEP - 1; i++) begin : g_order
		a_step_order: assert property (@(posedge clkcfg) disable iff (poweronreset)
			$fell(step_reset[i+1]) |-> !step_reset[i] && done[i])
			else begin
				fail_cnt++;
				$error("step %0d released out of order", i + 1);
			end
	end

endmodule

bind cfg_top cfg_top_chk #(.NSTEP(NSTEP), .RESET_LEN(RESET_LEN)) u_chk (.*);

`default_nettype wire

//--- verification/tb_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cfg_top;
	import cfg_pkg::*;
	import bus_pkg::*;

	`include "cfg_init_table.svh"

	localparam int NSTEP = NSTEP_DEFAULT;
	localparam int INIT_STEP = INIT_STEP_DEFAULT;
	localparam int RESET_LEN = 8;
	// two chain runs plus host traffic stay in the low hundreds of cycles
	localparam int TIMEOUT_CYC = 4000;
	localparam dev_dat_t RD_PATTERN = 32'hA5A5_A5A5;

	logic clkcfg;
	logic poweronreset;
	logic [NSTEP-2:0] ext_done;
	step_vec_t step_reset;
	logic host_cyc;
	logic host_stb;
	logic host_we;
	host_adr_t host_adr;
	host_dat_t host_dat_w;
	host_dat_t host_dat_r;
	logic host_ack;
	logic dev_cyc;
	logic dev_stb;
	logic dev_we;
	dev_adr_t dev_adr;
	dev_dat_t dev_dat_w;
	dev_dat_t dev_dat_r;
	logic dev_ack;

	integer seed = 71;
	dev_adr_t log_adr [$];  // device transfers in ack order
	dev_dat_t log_dat [$];
	logic log_we [$];

	cfg_top #(.NSTEP(NSTEP), .INIT_STEP(INIT_STEP), .RESET_LEN(RESET_LEN)) dut (.*);

	initial begin
		clkcfg = 1'b0;
		forever #4 clkcfg = ~clkcfg;
	end

	task automatic stop_fail(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
		stop_fail($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// ext_done bit k belongs to the k-th step that is not the init step
	function automatic int ext_step(input int k);
		return (k < INIT_STEP) ? k : k + 1;
	endfunction

	task automatic host_access(input logic we, input host_adr_t adr, input host_dat_t wdat,
			output host_dat_t rdat);
		@(negedge clkcfg);  // idle cycle between accesses
		host_cyc = 1'b1;
		host_stb = 1'b1;
		host_we = we;
		host_adr = adr;
		host_dat_w = wdat;
		do @(negedge clkcfg); while (host_ack !== 1'b1);
		rdat = host_dat_r;
		host_cyc = 1'b0;
		host_stb = 1'b0;
	endtask

	task automatic clear_log();
		log_adr.delete();
		log_dat.delete();
		log_we.delete();
	endtask

	task automatic check_xfer(input int k, input logic we, input dev_adr_t adr, input dev_dat_t dat);
		assert (log_we[k] == we) else value_error("dev_we", log_we[k], we);
		assert (log_adr[k] == adr) else value_error("dev_adr", log_adr[k], adr);
		assert (!we || log_dat[k] == dat) else value_error("dev_dat_w", log_dat[k], dat);
	endtask

	task automatic wait_step_release(input int s);
		while (step_reset[s] !== 1'b0)
			@(negedge clkcfg);
	endtask

	// init writes come first, queued host transfers only after them
	task automatic check_init_log(input int extra);
		assert (log_adr.size() == INIT_LEN + extra)
			else value_error("device transfer count", log_adr.size(), INIT_LEN + extra);
		for (int k = 0; k < INIT_LEN; k++)
			check_xfer(k, 1'b1, INIT_TABLE[k][39:32], INIT_TABLE[k][31:0]);
	endtask

	// poll status until chain_done, then every done bit must be up too
	task automatic wait_chain_done();
		host_dat_t st;
		st = '0;
		while (!st[NSTEP])
			host_access(1'b0, REG_STATUS, '0, st);
		assert (st == host_dat_t'((1 << (NSTEP + 1)) - 1))
			else value_error("host_dat_r", st, (1 << (NSTEP + 1)) - 1);
	endtask

	// device slave, random ack latency of 0 to 3 cycles
	initial begin : device_model
		int delay;
		dev_ack = 1'b0;
		dev_dat_r = '0;
		forever begin
			@(negedge clkcfg);
			if (dev_cyc === 1'b1 && dev_stb === 1'b1) begin
				delay = $random(seed) & 3;
				repeat (delay) @(negedge clkcfg);
				log_adr.push_back(dev_adr);
				log_dat.push_back(dev_dat_w);
				log_we.push_back(dev_we);
				dev_dat_r = dev_we ? '0 : (dev_dat_t'(dev_adr) ^ RD_PATTERN);
				dev_ack = 1'b1;
				@(negedge clkcfg);
				dev_ack = 1'b0;
			end
		end
	end

	initial begin : ext_done_model
		int cnt [NSTEP-1];
		ext_done = '0;
		foreach (cnt[k])
			cnt[k] = 0;
		forever begin
			@(negedge clkcfg);
			for (int k = 0; k < NSTEP - 1; k++) begin
				if (step_reset[ext_step(k)] !== 1'b0) begin
					ext_done[k] = 1'b0;
					cnt[k] = 2 + ($random(seed) & 15);  // settle time of the subsystem
				end else if (cnt[k] > 0) begin
					cnt[k]--;
				end else begin
					ext_done[k] = 1'b1;
				end
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(negedge clkcfg);
			cycles++;
			assert (cycles < TIMEOUT_CYC)
				else stop_fail($sformatf("timeout, run not finished after %0d cycles", cycles));
			assert (dut.u_chk.fail_cnt == 0)
				else stop_fail("a bound assertion in cfg_top_chk failed");
		end
	end

	initial begin : main
		host_dat_t rd;
		poweronreset = 1'b1;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
		host_adr = '0;
		host_dat_w = '0;
		repeat (10) @(negedge clkcfg);
		poweronreset = 1'b0;

		// first bring-up from power on, a live write queued while init still runs
		host_access(1'b1, REG_CMD_ADR, 32'h0000_003C, rd);
		host_access(1'b1, REG_CMD_DAT, 32'h0BAD_F00D, rd);  // stalls until init is done
		check_init_log(1);
		check_xfer(INIT_LEN, 1'b1, 8'h3C, 32'h0BAD_F00D);
		wait_chain_done();

		// live command write, then a read through the device
		host_access(1'b1, REG_CMD_ADR, 32'h0000_005A, rd);
		clear_log();
		host_access(1'b1, REG_CMD_DAT, 32'hCAFE_F00D, rd);
		host_access(1'b0, REG_CMD_DAT, '0, rd);
		assert (log_adr.size() == 2) else value_error("host transfer count", log_adr.size(), 2);
		check_xfer(0, 1'b1, 8'h5A, 32'hCAFE_F00D);
		check_xfer(1, 1'b0, 8'h5A, '0);
		assert (rd == (32'h0000_005A ^ RD_PATTERN))
			else value_error("host_dat_r", rd, 32'h0000_005A ^ RD_PATTERN);

		// restart replays the whole chain
		clear_log();
		host_access(1'b1, REG_RESTART, 32'h1, rd);
		@(negedge clkcfg);
		assert (step_reset == '1) else value_error("step_reset", step_reset, 4'hF);
		wait_step_release(NSTEP - 1);
		check_init_log(0);
		wait_chain_done();

		if (dut.u_chk.fail_cnt == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			stop_fail("bound assertion failures in cfg_top_chk");
		end
	end

endmodule

`default_nettype wire
